/* design/ipf_pkg.sv */
`default_nettype none

package ipf_pkg;

    // Sample, coordinate and offset widths
    localparam int PIXEL_W    = 8;
    localparam int COORD_W    = 7;
    localparam int OFFSET_W   = 4;
    localparam int OFFSET_NUM = 4;

    // Picture height in lines, the width comes from the top level
    localparam int IMG_HEIGHT = 128;

    // A band spans eight consecutive sample values
    localparam int BAND_SHIFT = 3;

    typedef logic [PIXEL_W-1:0]            pixel_t;
    typedef logic [COORD_W-1:0]            coord_t;
    typedef logic [2:0]                    lcu_pos_t;
    typedef logic [PIXEL_W-BAND_SHIFT-1:0] band_pos_t;
    typedef logic signed [OFFSET_W-1:0]    offset_t;

    // Element 0 sits in the top nibble of the offset word
    typedef offset_t [0:OFFSET_NUM-1] offset_set_t;

    // Code 3 decodes as horizontal edge as well
    typedef enum logic [1:0] {
        IPF_OFF    = 2'd0,
        IPF_BAND   = 2'd1,
        IPF_EDGE_H = 2'd2
    } ipf_mode_e;

    // Code 3 decodes as 64x64 as well
    typedef enum logic [1:0] {
        LCU_16 = 2'd0,
        LCU_32 = 2'd1,
        LCU_64 = 2'd2
    } lcu_size_e;

    // Signed add, saturated to the sample range
    function automatic pixel_t apply_offset(input pixel_t pix, input offset_t off);
        logic signed [PIXEL_W+1:0] sum;
        sum = $signed({2'b00, pix}) + (PIXEL_W+2)'(off);
        if (sum < 0) begin
            return '0;
        end
        else if (sum > $signed((PIXEL_W+2)'(2**PIXEL_W - 1))) begin
            return '1;
        end
        return pixel_t'(sum);
    endfunction

endpackage

`default_nettype wire

/* design/pixel_stream_if.sv */
`default_nettype none

interface pixel_stream_if import ipf_pkg::*; ();

    // One-cycle strobe, the other fields hold only while it is high
    logic   valid;
    pixel_t pixel;

    // Neighbours, used by the edge class only
    pixel_t left;
    pixel_t right;

    // Position inside the block
    coord_t col;
    coord_t row;
    logic   row_end;

    modport src (output valid, pixel, left, right, col, row, row_end);
    modport dst (input  valid, pixel, left, right, col, row, row_end);

endinterface

`default_nettype wire

/* design/lcu_cfg_if.sv */
`default_nettype none

interface lcu_cfg_if import ipf_pkg::*; ();

    ipf_mode_e   mode;
    band_pos_t   band_pos;
    offset_set_t offsets;

    // Block position in units of the block size
    lcu_pos_t    lcu_x;
    lcu_pos_t    lcu_y;

    // Block size minus one
    coord_t      last_idx;

    modport src (output mode, band_pos, offsets, lcu_x, lcu_y, last_idx);
    modport dst (input  mode, band_pos, offsets, lcu_x, lcu_y, last_idx);

endinterface

`default_nettype wire

/* design/lcu_scanner.sv */
`default_nettype none

module lcu_scanner import ipf_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_en,
    input  pixel_t      din,
    input  ipf_mode_e   ipf_type,
    input  band_pos_t   ipf_band_pos,
    input  logic [15:0] ipf_offset,
    input  lcu_pos_t    lcu_x,
    input  lcu_pos_t    lcu_y,
    input  lcu_size_e   lcu_size,
    output logic        busy,
    lcu_cfg_if.src      cfg,
    pixel_stream_if.src scan
);

    coord_t    col_cnt;
    coord_t    row_cnt;
    logic      accept;
    logic      at_origin;
    logic      last_col;
    logic      last_row;
    ipf_mode_e mode_in;
    coord_t    last_in;

    // Input side decode of the block settings
    always_comb begin
        if (ipf_type == IPF_OFF || ipf_type == IPF_BAND) begin
            mode_in = ipf_type;
        end
        else begin
            mode_in = IPF_EDGE_H;
        end
        case (lcu_size)
            LCU_16:  last_in = coord_t'(15);
            LCU_32:  last_in = coord_t'(31);
            default: last_in = coord_t'(63);
        endcase
    end

    assign accept    = in_en && !busy;
    assign at_origin = (col_cnt == '0) && (row_cnt == '0);
    assign last_col  = (col_cnt == cfg.last_idx);
    assign last_row  = (row_cnt == cfg.last_idx);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            col_cnt      <= '0;
            row_cnt      <= '0;
            busy         <= 1'b0;
            scan.valid   <= 1'b0;
            cfg.mode     <= IPF_OFF;
            cfg.band_pos <= '0;
            cfg.offsets  <= '0;
            cfg.lcu_x    <= '0;
            cfg.lcu_y    <= '0;
            cfg.last_idx <= coord_t'(63);
        end
        else begin
            scan.valid <= accept;
            // Flush slot after each row end of an edge block
            busy <= accept && last_col && (cfg.mode == IPF_EDGE_H);
            if (accept && at_origin) begin
                cfg.mode     <= mode_in;
                cfg.band_pos <= ipf_band_pos;
                cfg.offsets  <= offset_set_t'(ipf_offset);
                cfg.lcu_x    <= lcu_x;
                cfg.lcu_y    <= lcu_y;
                cfg.last_idx <= last_in;
            end
            if (accept) begin
                if (last_col) begin
                    col_cnt <= '0;
                    row_cnt <= last_row ? '0 : row_cnt + coord_t'(1);
                end
                else begin
                    col_cnt <= col_cnt + coord_t'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            scan.pixel   <= din;
            scan.col     <= col_cnt;
            scan.row     <= row_cnt;
            scan.row_end <= last_col;
        end
    end

    // No neighbours yet at this stage
    assign scan.left  = '0;
    assign scan.right = '0;

endmodule

`default_nettype wire

/* design/edge_window.sv */
`default_nettype none

module edge_window import ipf_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    lcu_cfg_if.dst      cfg,
    pixel_stream_if.dst scan,
    pixel_stream_if.src win
);

    pixel_t left_q;
    pixel_t centre_q;
    coord_t col_q;
    logic   flush_q;
    logic   edge_mode;
    logic   emit;
    pixel_t emit_pixel;
    pixel_t emit_left;
    pixel_t emit_right;
    coord_t emit_col;
    logic   emit_end;

    assign edge_mode = (cfg.mode == IPF_EDGE_H);

    // Busy keeps the scan stream empty during a flush cycle
    always_comb begin
        emit = flush_q || (scan.valid && (!edge_mode || scan.col != '0));
        if (flush_q) begin
            // Last pixel of the row has no right neighbour
            emit_pixel = centre_q;
            emit_left  = left_q;
            emit_right = '0;
            emit_col   = col_q;
            emit_end   = 1'b1;
        end
        else if (edge_mode) begin
            emit_pixel = centre_q;
            emit_left  = left_q;
            emit_right = scan.pixel;
            emit_col   = col_q;
            emit_end   = 1'b0;
        end
        else begin
            emit_pixel = scan.pixel;
            emit_left  = '0;
            emit_right = '0;
            emit_col   = scan.col;
            emit_end   = scan.row_end;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            left_q    <= '0;
            centre_q  <= '0;
            flush_q   <= 1'b0;
            win.valid <= 1'b0;
        end
        else begin
            win.valid <= emit;
            if (flush_q) begin
                // Windows never reach across a row boundary
                left_q   <= '0;
                centre_q <= '0;
                flush_q  <= 1'b0;
            end
            else if (scan.valid && edge_mode) begin
                left_q   <= centre_q;
                centre_q <= scan.pixel;
                flush_q  <= scan.row_end;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (scan.valid && edge_mode) begin
            col_q <= scan.col;
        end
        if (emit) begin
            win.pixel   <= emit_pixel;
            win.left    <= emit_left;
            win.right   <= emit_right;
            win.col     <= emit_col;
            win.row     <= scan.row;
            win.row_end <= emit_end;
        end
    end

endmodule

`default_nettype wire

/* design/offset_apply.sv */
`default_nettype none

module offset_apply import ipf_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    lcu_cfg_if.dst      cfg,
    pixel_stream_if.dst win,
    output logic        out_en,
    output pixel_t      dout
);

    logic          blk_start;
    ipf_mode_e     mode_q;
    band_pos_t     band_pos_q;
    offset_set_t   offsets_q;
    ipf_mode_e     mode;
    band_pos_t     band_pos;
    offset_set_t   offsets;
    band_pos_t     band;
    logic [PIXEL_W:0] twice_c;
    logic [PIXEL_W:0] sum_lr;
    logic          use_off;
    logic [1:0]    off_idx;
    pixel_t        result;

    // Settings may already belong to the next block, so keep a copy from
    // the first pixel of each block
    assign blk_start = win.valid && (win.col == '0) && (win.row == '0);
    assign mode      = blk_start ? cfg.mode : mode_q;
    assign band_pos  = blk_start ? cfg.band_pos : band_pos_q;
    assign offsets   = blk_start ? cfg.offsets : offsets_q;

    assign band    = band_pos_t'(win.pixel >> BAND_SHIFT);
    assign twice_c = {win.pixel, 1'b0};
    assign sum_lr  = {1'b0, win.left} + {1'b0, win.right};

    always_comb begin
        use_off = 1'b0;
        off_idx = 2'd0;
        case (mode)
            IPF_BAND: begin
                // Bands next to band_pos are protected, compared without wrap
                use_off = !(({1'b0, band} == {1'b0, band_pos}) ||
                            ({1'b0, band} + 6'd1 == {1'b0, band_pos}) ||
                            ({1'b0, band} == {1'b0, band_pos} + 6'd1));
                off_idx = band[1:0];
            end
            IPF_EDGE_H: begin
                if (win.col != '0 && !win.row_end) begin
                    use_off = 1'b1;
                    if (win.pixel < win.left && win.pixel < win.right) begin
                        off_idx = 2'd0;
                    end
                    else if (win.pixel > win.left && win.pixel > win.right) begin
                        off_idx = 2'd3;
                    end
                    else if (twice_c < sum_lr) begin
                        off_idx = 2'd1;
                    end
                    else if (twice_c > sum_lr) begin
                        off_idx = 2'd2;
                    end
                    else begin
                        use_off = 1'b0;
                    end
                end
            end
            default: use_off = 1'b0;
        endcase
        result = use_off ? apply_offset(win.pixel, offsets[off_idx]) : win.pixel;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mode_q     <= IPF_OFF;
            band_pos_q <= '0;
            offsets_q  <= '0;
            out_en     <= 1'b0;
            dout       <= '0;
        end
        else begin
            out_en <= win.valid;
            if (blk_start) begin
                mode_q     <= cfg.mode;
                band_pos_q <= cfg.band_pos;
                offsets_q  <= cfg.offsets;
            end
            if (win.valid) begin
                dout <= result;
            end
        end
    end

endmodule

`default_nettype wire

/* design/frame_addr.sv */
`default_nettype none

module frame_addr import ipf_pkg::*; #(
    parameter  int IMG_WIDTH = 128,
    localparam int ADDR_W    = $clog2(IMG_WIDTH * IMG_HEIGHT)
) (
    input  logic              clk,
    input  logic              reset,
    lcu_cfg_if.dst            cfg,
    pixel_stream_if.dst       win,
    output logic [ADDR_W-1:0] dout_addr,
    output logic              finish
);

    localparam int LAST_ADDR = IMG_WIDTH * IMG_HEIGHT - 1;

    logic               blk_start;
    lcu_pos_t           lcu_x_q;
    lcu_pos_t           lcu_y_q;
    coord_t             last_q;
    lcu_pos_t           x_sel;
    lcu_pos_t           y_sel;
    logic [COORD_W:0]   blk_size;
    logic [ADDR_W-1:0]  pic_x;
    logic [ADDR_W-1:0]  pic_y;
    logic [ADDR_W-1:0]  addr_next;

    // Same per-block hold as the value stage
    assign blk_start = win.valid && (win.col == '0) && (win.row == '0);
    assign x_sel     = blk_start ? cfg.lcu_x : lcu_x_q;
    assign y_sel     = blk_start ? cfg.lcu_y : lcu_y_q;
    assign blk_size  = {1'b0, blk_start ? cfg.last_idx : last_q} + (COORD_W+1)'(1);

    assign pic_x     = ADDR_W'(x_sel) * ADDR_W'(blk_size) + ADDR_W'(win.col);
    assign pic_y     = ADDR_W'(y_sel) * ADDR_W'(blk_size) + ADDR_W'(win.row);
    assign addr_next = pic_y * ADDR_W'(IMG_WIDTH) + pic_x;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lcu_x_q   <= '0;
            lcu_y_q   <= '0;
            last_q    <= '0;
            dout_addr <= '0;
            finish    <= 1'b0;
        end
        else begin
            if (blk_start) begin
                lcu_x_q <= cfg.lcu_x;
                lcu_y_q <= cfg.lcu_y;
                last_q  <= cfg.last_idx;
            end
            if (win.valid) begin
                dout_addr <= addr_next;
            end
            finish <= win.valid && (addr_next == ADDR_W'(LAST_ADDR));
        end
    end

endmodule

`default_nettype wire

/* design/ipf_top.sv */
`default_nettype none

module ipf_top import ipf_pkg::*; #(
    parameter  int IMG_WIDTH = 128,
    localparam int ADDR_W    = $clog2(IMG_WIDTH * IMG_HEIGHT)
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_en,
    input  pixel_t            din,
    input  ipf_mode_e         ipf_type,
    input  band_pos_t         ipf_band_pos,
    input  logic [15:0]       ipf_offset,
    input  lcu_pos_t          lcu_x,
    input  lcu_pos_t          lcu_y,
    input  lcu_size_e         lcu_size,
    output logic              busy,
    output logic              out_en,
    output logic              finish,
    output pixel_t            dout,
    output logic [ADDR_W-1:0] dout_addr
);

    lcu_cfg_if      cfg_bus ();
    pixel_stream_if scan_bus ();
    pixel_stream_if win_bus ();

    lcu_scanner lcu_scanner_inst (
        .clk          (clk),
        .reset        (reset),
        .in_en        (in_en),
        .din          (din),
        .ipf_type     (ipf_type),
        .ipf_band_pos (ipf_band_pos),
        .ipf_offset   (ipf_offset),
        .lcu_x        (lcu_x),
        .lcu_y        (lcu_y),
        .lcu_size     (lcu_size),
        .busy         (busy),
        .cfg          (cfg_bus),
        .scan         (scan_bus)
    );

    edge_window edge_window_inst (
        .clk   (clk),
        .reset (reset),
        .cfg   (cfg_bus),
        .scan  (scan_bus),
        .win   (win_bus)
    );

    // Value and address stages run in lockstep off the same window stream
    offset_apply offset_apply_inst (
        .clk    (clk),
        .reset  (reset),
        .cfg    (cfg_bus),
        .win    (win_bus),
        .out_en (out_en),
        .dout   (dout)
    );

    frame_addr #(
        .IMG_WIDTH (IMG_WIDTH)
    ) frame_addr_inst (
        .clk       (clk),
        .reset     (reset),
        .cfg       (cfg_bus),
        .win       (win_bus),
        .dout_addr (dout_addr),
        .finish    (finish)
    );

endmodule

`default_nettype wire

/* tb/ipf_tb.sv */
`default_nettype none

module ipf_tb import ipf_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int IMG_WIDTH  = 128;
    localparam int ADDR_W     = 14;
    localparam int LAST_ADDR  = 16383;
    localparam int JOB_FIELDS = 8;
    localparam int MAX_JOBS   = 32;
    localparam logic [31:0] LCG_SEED = 32'd30;
    localparam pixel_t IDLE_LIMIT = 8'd40;

    typedef logic [ADDR_W-1:0] addr_t;

    logic        clk;
    logic        reset;
    logic        in_en;
    pixel_t      din;
    ipf_mode_e   ipf_type;
    band_pos_t   ipf_band_pos;
    logic [15:0] ipf_offset;
    lcu_pos_t    lcu_x;
    lcu_pos_t    lcu_y;
    lcu_size_e   lcu_size;
    logic        busy;
    logic        out_en;
    logic        finish;
    pixel_t      dout;
    addr_t       dout_addr;

    // Job table as read from the stimulus file, eight words per job
    logic [15:0] job_words [0:MAX_JOBS*JOB_FIELDS-1];
    int          job_seen [0:MAX_JOBS-1];
    pixel_t      blk [0:4095];
    logic [31:0] lcg_state;

    // Expected output beats, in output order
    pixel_t      exp_pix [$];
    addr_t       exp_addr [$];
    int          exp_cyc [$];
    int          exp_job [$];

    int          cyc;
    int          busy_cycles;
    int          finish_count;
    longint      watchdog_cycles;
    pixel_t      exp_p;
    addr_t       exp_a;
    int          exp_c;
    int          exp_j;

    ipf_top #(
        .IMG_WIDTH (IMG_WIDTH)
    ) ipf_top_inst (
        .clk          (clk),
        .reset        (reset),
        .in_en        (in_en),
        .din          (din),
        .ipf_type     (ipf_type),
        .ipf_band_pos (ipf_band_pos),
        .ipf_offset   (ipf_offset),
        .lcu_x        (lcu_x),
        .lcu_y        (lcu_y),
        .lcu_size     (lcu_size),
        .busy         (busy),
        .out_en       (out_en),
        .finish       (finish),
        .dout         (dout),
        .dout_addr    (dout_addr)
    );

    always #20 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped after an error");
    endtask

    task automatic check_pixel(input string name, input pixel_t act, input pixel_t exp);
        if (act !== exp) begin
            abort_run($sformatf("ERROR at time %0t: %s expected %0d, got %0d",
                                $time, name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input addr_t act, input addr_t exp);
        if (act !== exp) begin
            abort_run($sformatf("ERROR at time %0t: %s expected %0d, got %0d",
                                $time, name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            abort_run($sformatf("ERROR at time %0t: %s expected %b, got %b",
                                $time, name, exp, act));
        end
    endtask

    task automatic verify_reset_state();
        check_flag("busy", busy, 1'b0);
        check_flag("out_en", out_en, 1'b0);
        check_flag("finish", finish, 1'b0);
        check_pixel("dout", dout, 8'd0);
        check_addr("dout_addr", dout_addr, '0);
    endtask

    function automatic pixel_t rand_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    function automatic int block_size(input logic [15:0] code);
        case (code[1:0])
            2'd0:    return 16;
            2'd1:    return 32;
            default: return 64;
        endcase
    endfunction

    // Nibble 0 is the top one of the offset word
    function automatic int offset_val(input logic [15:0] word, input int idx);
        offset_t off;
        off = offset_t'(word >> (4 * (3 - idx)));
        return int'(off);
    endfunction

    function automatic pixel_t clamp_add(input int p, input int off);
        int s;
        s = p + off;
        if (s < 0) begin
            return 8'd0;
        end
        if (s > 255) begin
            return 8'd255;
        end
        return pixel_t'(s);
    endfunction

    // Expected value of one block pixel, taken from blk
    function automatic pixel_t model_pixel(input int mode, input int size, input int bp,
                                           input logic [15:0] offw, input int r, input int c);
        int p;
        int band;
        int l;
        int rt;
        int idx;
        p = int'(blk[r * size + c]);
        if (mode == 0) begin
            return pixel_t'(p);
        end
        if (mode == 1) begin
            band = p >> BAND_SHIFT;
            if (band == bp || band == bp - 1 || band == bp + 1) begin
                return pixel_t'(p);
            end
            return clamp_add(p, offset_val(offw, band % 4));
        end
        if (c == 0 || c == size - 1) begin
            return pixel_t'(p);
        end
        l  = int'(blk[r * size + c - 1]);
        rt = int'(blk[r * size + c + 1]);
        if (p < l && p < rt) begin
            idx = 0;
        end
        else if (p > l && p > rt) begin
            idx = 3;
        end
        else if (2 * p < l + rt) begin
            idx = 1;
        end
        else if (2 * p > l + rt) begin
            idx = 2;
        end
        else begin
            return pixel_t'(p);
        end
        return clamp_add(p, offset_val(offw, idx));
    endfunction

    task automatic drive_job(input int j);
        int     base;
        int     mode;
        int     size;
        int     bp;
        int     bx;
        int     by;
        int     i;
        int     r;
        int     c;
        pixel_t junk;
        base = j * JOB_FIELDS;
        mode = int'(job_words[base]);
        size = block_size(job_words[base + 1]);
        bx   = int'(job_words[base + 2]);
        by   = int'(job_words[base + 3]);
        bp   = int'(job_words[base + 4]);
        for (i = 0; i < size * size; i++) begin
            blk[i] = rand_byte();
        end
        for (i = 0; i < size * size; i++) begin
            r = i / size;
            c = i % size;
            // First job runs without gaps for the latency check
            if (j > 0 && rand_byte() < IDLE_LIMIT) begin
                in_en = 1'b0;
                @(negedge clk);
            end
            while (busy) begin
                in_en = 1'b0;
                @(negedge clk);
            end
            if (i == 0) begin
                ipf_type     = ipf_mode_e'(job_words[base][1:0]);
                lcu_size     = lcu_size_e'(job_words[base + 1][1:0]);
                lcu_x        = lcu_pos_t'(job_words[base + 2]);
                lcu_y        = lcu_pos_t'(job_words[base + 3]);
                ipf_band_pos = band_pos_t'(job_words[base + 4]);
                ipf_offset   = job_words[base + 5];
            end
            else begin
                // Block settings must be ignored after the first pixel
                junk         = rand_byte();
                ipf_type     = ipf_mode_e'(junk[1:0]);
                lcu_size     = lcu_size_e'(junk[3:2]);
                lcu_x        = junk[6:4];
                lcu_y        = junk[7:5];
                ipf_band_pos = junk[4:0];
                ipf_offset   = {junk, ~junk};
            end
            in_en = 1'b1;
            din   = blk[i];
            exp_pix.push_back(model_pixel(mode, size, bp, job_words[base + 5], r, c));
            exp_addr.push_back(addr_t'((by * size + r) * IMG_WIDTH + bx * size + c));
            exp_cyc.push_back((mode >= 2) ? -1 : cyc + 4);
            exp_job.push_back(j);
            @(negedge clk);
        end
    endtask

    // Output monitor, reads values settled by the previous edge
    always @(posedge clk) begin
        cyc = cyc + 1;
        if (busy) begin
            busy_cycles = busy_cycles + 1;
        end
        if (out_en) begin
            if (exp_pix.size() == 0) begin
                abort_run("An output beat arrived with no pixel left to expect");
            end
            else begin
                exp_p = exp_pix.pop_front();
                exp_a = exp_addr.pop_front();
                exp_c = exp_cyc.pop_front();
                exp_j = exp_job.pop_front();
                check_pixel("dout", dout, exp_p);
                check_addr("dout_addr", dout_addr, exp_a);
                check_flag("finish", finish, exp_a == addr_t'(LAST_ADDR));
                if (exp_c >= 0 && cyc != exp_c) begin
                    abort_run($sformatf("ERROR at time %0t: out_en expected at cycle %0d, got %0d",
                                        $time, exp_c, cyc));
                end
                if (job_seen[exp_j] == 0) begin
                    check_addr("first dout_addr of job", dout_addr,
                               addr_t'(job_words[exp_j * JOB_FIELDS + 7]));
                end
                job_seen[exp_j] = job_seen[exp_j] + 1;
                if (finish) begin
                    finish_count = finish_count + 1;
                end
            end
        end
        else begin
            check_flag("finish", finish, 1'b0);
        end
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        abort_run($sformatf("Timeout: the run did not end within %0d clock cycles",
                            watchdog_cycles));
    end

    initial begin
        int    num_jobs;
        int    total_pixels;
        int    exp_busy;
        int    size;
        int    k;
        int    wait_cnt;
        string problem;
        clk          = 1'b0;
        reset        = 1'b1;
        in_en        = 1'b0;
        din          = '0;
        ipf_type     = IPF_OFF;
        ipf_band_pos = '0;
        ipf_offset   = '0;
        lcu_x        = '0;
        lcu_y        = '0;
        lcu_size     = LCU_16;
        lcg_state    = LCG_SEED;
        cyc          = 0;
        busy_cycles  = 0;
        finish_count = 0;
        for (k = 0; k < MAX_JOBS * JOB_FIELDS; k++) begin
            job_words[k] = '1;
        end
        for (k = 0; k < MAX_JOBS; k++) begin
            job_seen[k] = 0;
        end
        $readmemh("tb/ipf_stimulus.txt", job_words);

        // Unused table words keep the all-ones end marker
        num_jobs     = 0;
        total_pixels = 0;
        exp_busy     = 0;
        while (num_jobs < MAX_JOBS && job_words[num_jobs * JOB_FIELDS] != 16'hffff) begin
            size = block_size(job_words[num_jobs * JOB_FIELDS + 1]);
            total_pixels = total_pixels + size * size;
            if (job_words[num_jobs * JOB_FIELDS] >= 16'd2) begin
                exp_busy = exp_busy + size;
            end
            num_jobs = num_jobs + 1;
        end
        watchdog_cycles = longint'(total_pixels + 64) * 4;

        repeat (10) begin
            @(negedge clk);
            verify_reset_state();
        end
        reset = 1'b0;
        @(negedge clk);
        verify_reset_state();

        for (k = 0; k < num_jobs; k++) begin
            drive_job(k);
        end
        in_en = 1'b0;

        wait_cnt = 0;
        while (exp_pix.size() != 0 && wait_cnt < 50) begin
            @(negedge clk);
            wait_cnt = wait_cnt + 1;
        end
        // A few more cycles to catch stray output beats
        repeat (8) @(negedge clk);

        problem = "";
        if (exp_pix.size() != 0) begin
            problem = $sformatf("%0d output pixels never came out", exp_pix.size());
        end
        else if (finish_count != 1) begin
            problem = $sformatf("finish pulsed %0d times instead of once", finish_count);
        end
        else if (busy_cycles != exp_busy) begin
            problem = $sformatf("busy was high for %0d cycles, one per edge row gives %0d",
                                busy_cycles, exp_busy);
        end
        for (k = 0; k < num_jobs; k++) begin
            if (problem.len() == 0 && job_seen[k] != int'(job_words[k * JOB_FIELDS + 6])) begin
                problem = $sformatf("Job %0d gave %0d outputs instead of %0d", k, job_seen[k],
                                    int'(job_words[k * JOB_FIELDS + 6]));
            end
        end

        if (problem.len() == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end
        else begin
            abort_run(problem);
        end
    end

endmodule

`default_nettype wire

/* tb/ipf_stimulus.txt */
// Columns (hex): mode size lcu_x lcu_y band_pos offset_word out_count first_addr
// mode 0 bypass, 1 band, 2 or 3 edge; size 0 is 16, 1 is 32, 2 or 3 is 64
// Bypass, the first job runs without idle cycles
0 0 0 0 00 0000 0100 0000
0 1 1 0 00 0000 0400 0020
// Band offset, then clamping at 255 and at 0
1 0 2 1 10 7f18 0100 0820
1 1 3 1 00 7777 0400 1060
1 0 0 4 1f 8888 0100 2000
// Horizontal edge, mode code 3 as an alias
2 0 5 2 00 42ec 0100 1050
3 1 0 2 00 71f8 0400 2000
// 64x64 blocks, the last one ends at the bottom right of the picture
0 3 0 0 00 0000 1000 0000
1 2 1 0 0c 1f3d 1000 0040
2 2 1 1 00 5a3c 1000 2040

/* sim.f */
design/ipf_pkg.sv
design/pixel_stream_if.sv
design/lcu_cfg_if.sv
design/lcu_scanner.sv
design/edge_window.sv
design/offset_apply.sv
design/frame_addr.sv
design/ipf_top.sv
tb/ipf_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project root"
    exit 1
fi

verilator --binary --timing --top-module ipf_tb -f sim.f -o ipf_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/ipf_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qF "*** TEST PASSED ***"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
